// File: design/mem_map_pkg.sv
package mem_map_pkg;

   // Bus widths.
   localparam int unsigned ADDR_W         = 16;
   localparam int unsigned DATA_W_DEFAULT = 8;

   localparam int unsigned N_MASTERS = 4;
   localparam int unsigned N_REGIONS = 6;

   // Master indices. A lower index wins the grant.
   localparam int unsigned M_CPU  = 0;
   localparam int unsigned M_PPU  = 1;
   localparam int unsigned M_RDMA = 2;
   localparam int unsigned M_WDMA = 3;

   // Region indices double as the bit positions in every select vector.
   localparam int unsigned R_CART   = 0;
   localparam int unsigned R_LCDRAM = 1;
   localparam int unsigned R_WRAM   = 2;
   localparam int unsigned R_OAM    = 3;
   localparam int unsigned R_IOREG  = 4;
   localparam int unsigned R_LWRAM  = 5;

   // Region bounds. LO is inclusive and HI is exclusive.
   localparam logic [ADDR_W-1:0] CART_LO   = 16'h0000;
   localparam logic [ADDR_W-1:0] CART_HI   = 16'h8000;

   localparam logic [ADDR_W-1:0] LCDRAM_LO = 16'h8000;
   localparam logic [ADDR_W-1:0] LCDRAM_HI = 16'hA000;

   // The window from 0xA000 to 0xBFFF is not mapped.
   localparam logic [ADDR_W-1:0] WRAM_LO   = 16'hC000;
   localparam logic [ADDR_W-1:0] WRAM_HI   = 16'hE000;

   localparam logic [ADDR_W-1:0] OAM_LO    = 16'hFE00;
   localparam logic [ADDR_W-1:0] OAM_HI    = 16'hFEA0;

   localparam logic [ADDR_W-1:0] IOREG_LO  = 16'hFF00;
   localparam logic [ADDR_W-1:0] IOREG_HI  = 16'hFF80;

   // The top address 0xFFFF falls outside the high working RAM.
   localparam logic [ADDR_W-1:0] LWRAM_LO  = 16'hFF80;
   localparam logic [ADDR_W-1:0] LWRAM_HI  = 16'hFFFF;

endpackage

// File: design/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
   input  logic [mem_map_pkg::ADDR_W-1:0]    addr,
   input  logic                              we_n,
   input  logic                              re_n,
   output logic [mem_map_pkg::N_REGIONS-1:0] sel
);

   logic active;

   assign active = ~we_n | ~re_n; // Either strobe low is a request.

   assign sel[mem_map_pkg::R_CART]   = active &&
                                       (addr >= mem_map_pkg::CART_LO) &&
                                       (addr <  mem_map_pkg::CART_HI);

   assign sel[mem_map_pkg::R_LCDRAM] = active &&
                                       (addr >= mem_map_pkg::LCDRAM_LO) &&
                                       (addr <  mem_map_pkg::LCDRAM_HI);

   assign sel[mem_map_pkg::R_WRAM]   = active &&
                                       (addr >= mem_map_pkg::WRAM_LO) &&
                                       (addr <  mem_map_pkg::WRAM_HI);

   assign sel[mem_map_pkg::R_OAM]    = active &&
                                       (addr >= mem_map_pkg::OAM_LO) &&
                                       (addr <  mem_map_pkg::OAM_HI);

   assign sel[mem_map_pkg::R_IOREG]  = active &&
                                       (addr >= mem_map_pkg::IOREG_LO) &&
                                       (addr <  mem_map_pkg::IOREG_HI);

   assign sel[mem_map_pkg::R_LWRAM]  = active &&
                                       (addr >= mem_map_pkg::LWRAM_LO) &&
                                       (addr <  mem_map_pkg::LWRAM_HI);

endmodule

// File: design/region_port.sv
`timescale 1ns/1ps

module region_port #(
   parameter int unsigned DATA_W = 8
) (
   input  logic [mem_map_pkg::N_MASTERS-1:0]                           req,
   input  logic [mem_map_pkg::N_MASTERS-1:0][mem_map_pkg::ADDR_W-1:0]  master_addr,
   input  logic [mem_map_pkg::N_MASTERS-1:0][DATA_W-1:0]               master_wdata,
   input  logic [mem_map_pkg::N_MASTERS-1:0]                           master_we_n,
   input  logic [mem_map_pkg::N_MASTERS-1:0]                           master_re_n,
   output logic [mem_map_pkg::ADDR_W-1:0]                              addr,
   output logic [DATA_W-1:0]                                           wdata,
   output logic                                                        we_n,
   output logic                                                        re_n
);

   // The region sits idle unless some master requests it.
   // The loop walks from the highest index down, so the lowest requesting
   // index is the last one written and wins the region.
   always_comb begin
      addr  = '0;
      wdata = '0;
      we_n  = 1'b1;
      re_n  = 1'b1;
      for (int m = mem_map_pkg::N_MASTERS - 1; m >= 0; m--) begin
         if (req[m]) begin
            addr  = master_addr[m];
            wdata = master_wdata[m];
            we_n  = master_we_n[m];
            re_n  = master_re_n[m]; // Both strobes pass as the master drives them.
         end
      end
   end

endmodule

// File: design/read_return.sv
`timescale 1ns/1ps

module read_return #(
   parameter int unsigned DATA_W = 8
) (
   input  logic [mem_map_pkg::N_REGIONS-1:0]             sel,
   input  logic                                          re_n,
   input  logic [mem_map_pkg::N_REGIONS-1:0][DATA_W-1:0] region_rdata,
   output logic [DATA_W-1:0]                             rdata
);

   // The select vector is one-hot, so an OR of the masked region data
   // yields the one selected value. No select gives zero.
   always_comb begin
      rdata = '0;
      if (!re_n) begin
         for (int r = 0; r < mem_map_pkg::N_REGIONS; r++) begin
            if (sel[r]) begin
               rdata = rdata | region_rdata[r];
            end
         end
      end
   end

endmodule

// File: design/access_monitor.sv
`timescale 1ns/1ps

module access_monitor (
   input  logic                              clk,
   input  logic                              arst_n,
   input  logic [mem_map_pkg::N_REGIONS-1:0] sel_cpu,
   input  logic [mem_map_pkg::N_REGIONS-1:0] sel_ppu,
   input  logic [mem_map_pkg::N_REGIONS-1:0] sel_rdma,
   input  logic [mem_map_pkg::N_REGIONS-1:0] sel_wdma,
   output logic                              same_port_error
);

   logic [mem_map_pkg::N_REGIONS-1:0] region_clash;

   // A region clashes when two or more of the four masters select it.
   always_comb begin
      logic [2:0] hits;
      hits = '0;
      for (int r = 0; r < mem_map_pkg::N_REGIONS; r++) begin
         hits = {2'b00, sel_cpu[r]} + {2'b00, sel_ppu[r]} +
                {2'b00, sel_rdma[r]} + {2'b00, sel_wdma[r]};
         region_clash[r] = (hits >= 3'd2);
      end
   end

   // Sticky flag. Once set it holds until the next reset.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         same_port_error <= 1'b0;
      end else if (|region_clash) begin
         same_port_error <= 1'b1;
      end
   end

endmodule

// File: design/memory_router.sv
`timescale 1ns/1ps

module memory_router #(
   parameter int unsigned DATA_W = mem_map_pkg::DATA_W_DEFAULT
) (
   input  logic                           clk,
   input  logic                           arst_n,

   input  logic [mem_map_pkg::ADDR_W-1:0] cpu_addr,
   input  logic [DATA_W-1:0]              cpu_wdata,
   input  logic                           cpu_we_n,
   input  logic                           cpu_re_n,
   output logic [DATA_W-1:0]              cpu_rdata,

   input  logic [mem_map_pkg::ADDR_W-1:0] ppu_addr,
   input  logic [DATA_W-1:0]              ppu_wdata,
   input  logic                           ppu_we_n,
   input  logic                           ppu_re_n,
   output logic [DATA_W-1:0]              ppu_rdata,

   input  logic [mem_map_pkg::ADDR_W-1:0] rdma_addr,
   input  logic                           rdma_re_n,
   output logic [DATA_W-1:0]              rdma_rdata,

   input  logic [mem_map_pkg::ADDR_W-1:0] wdma_addr,
   input  logic [DATA_W-1:0]              wdma_wdata,
   input  logic                           wdma_we_n,

   output logic [mem_map_pkg::ADDR_W-1:0] cart_addr,
   output logic [DATA_W-1:0]              cart_wdata,
   output logic                           cart_we_n,
   output logic                           cart_re_n,
   input  logic [DATA_W-1:0]              cart_rdata,

   output logic [mem_map_pkg::ADDR_W-1:0] lcdram_addr,
   output logic [DATA_W-1:0]              lcdram_wdata,
   output logic                           lcdram_we_n,
   output logic                           lcdram_re_n,
   input  logic [DATA_W-1:0]              lcdram_rdata,

   output logic [mem_map_pkg::ADDR_W-1:0] wram_addr,
   output logic [DATA_W-1:0]              wram_wdata,
   output logic                           wram_we_n,
   output logic                           wram_re_n,
   input  logic [DATA_W-1:0]              wram_rdata,

   output logic [mem_map_pkg::ADDR_W-1:0] oam_addr,
   output logic [DATA_W-1:0]              oam_wdata,
   output logic                           oam_we_n,
   output logic                           oam_re_n,
   input  logic [DATA_W-1:0]              oam_rdata,

   output logic [mem_map_pkg::ADDR_W-1:0] ioreg_addr,
   output logic [DATA_W-1:0]              ioreg_wdata,
   output logic                           ioreg_we_n,
   output logic                           ioreg_re_n,
   input  logic [DATA_W-1:0]              ioreg_rdata,

   output logic [mem_map_pkg::ADDR_W-1:0] lwram_addr,
   output logic [DATA_W-1:0]              lwram_wdata,
   output logic                           lwram_we_n,
   output logic                           lwram_re_n,
   input  logic [DATA_W-1:0]              lwram_rdata,

   output logic                           same_port_error
);

   logic [mem_map_pkg::N_REGIONS-1:0] sel_cpu;
   logic [mem_map_pkg::N_REGIONS-1:0] sel_ppu;
   logic [mem_map_pkg::N_REGIONS-1:0] sel_rdma;
   logic [mem_map_pkg::N_REGIONS-1:0] sel_wdma;

   // Master buses gathered by master index for the region ports.
   logic [mem_map_pkg::N_MASTERS-1:0][mem_map_pkg::ADDR_W-1:0] m_addr;
   logic [mem_map_pkg::N_MASTERS-1:0][DATA_W-1:0]              m_wdata;
   logic [mem_map_pkg::N_MASTERS-1:0]                          m_we_n;
   logic [mem_map_pkg::N_MASTERS-1:0]                          m_re_n;

   logic [mem_map_pkg::N_REGIONS-1:0][mem_map_pkg::N_MASTERS-1:0] region_req;
   logic [mem_map_pkg::N_REGIONS-1:0][DATA_W-1:0]                 region_rdata;

   assign m_addr[mem_map_pkg::M_CPU]   = cpu_addr;
   assign m_addr[mem_map_pkg::M_PPU]   = ppu_addr;
   assign m_addr[mem_map_pkg::M_RDMA]  = rdma_addr;
   assign m_addr[mem_map_pkg::M_WDMA]  = wdma_addr;

   assign m_wdata[mem_map_pkg::M_CPU]  = cpu_wdata;
   assign m_wdata[mem_map_pkg::M_PPU]  = ppu_wdata;
   assign m_wdata[mem_map_pkg::M_RDMA] = '0; // The DMA read port never writes.
   assign m_wdata[mem_map_pkg::M_WDMA] = wdma_wdata;

   assign m_we_n[mem_map_pkg::M_CPU]   = cpu_we_n;
   assign m_we_n[mem_map_pkg::M_PPU]   = ppu_we_n;
   assign m_we_n[mem_map_pkg::M_RDMA]  = 1'b1;
   assign m_we_n[mem_map_pkg::M_WDMA]  = wdma_we_n;

   assign m_re_n[mem_map_pkg::M_CPU]   = cpu_re_n;
   assign m_re_n[mem_map_pkg::M_PPU]   = ppu_re_n;
   assign m_re_n[mem_map_pkg::M_RDMA]  = rdma_re_n;
   assign m_re_n[mem_map_pkg::M_WDMA]  = 1'b1;

   for (genvar r = 0; r < mem_map_pkg::N_REGIONS; r++) begin : g_req
      assign region_req[r][mem_map_pkg::M_CPU]  = sel_cpu[r];
      assign region_req[r][mem_map_pkg::M_PPU]  = sel_ppu[r];
      assign region_req[r][mem_map_pkg::M_RDMA] = sel_rdma[r];
      assign region_req[r][mem_map_pkg::M_WDMA] = sel_wdma[r];
   end

   assign region_rdata[mem_map_pkg::R_CART]   = cart_rdata;
   assign region_rdata[mem_map_pkg::R_LCDRAM] = lcdram_rdata;
   assign region_rdata[mem_map_pkg::R_WRAM]   = wram_rdata;
   assign region_rdata[mem_map_pkg::R_OAM]    = oam_rdata;
   assign region_rdata[mem_map_pkg::R_IOREG]  = ioreg_rdata;
   assign region_rdata[mem_map_pkg::R_LWRAM]  = lwram_rdata;

   addr_decoder u_dec_cpu (
      .addr(cpu_addr), .we_n(cpu_we_n), .re_n(cpu_re_n), .sel(sel_cpu)
   );
   addr_decoder u_dec_ppu (
      .addr(ppu_addr), .we_n(ppu_we_n), .re_n(ppu_re_n), .sel(sel_ppu)
   );
   addr_decoder u_dec_rdma (
      .addr(rdma_addr), .we_n(1'b1), .re_n(rdma_re_n), .sel(sel_rdma)
   );
   addr_decoder u_dec_wdma (
      .addr(wdma_addr), .we_n(wdma_we_n), .re_n(1'b1), .sel(sel_wdma)
   );

   region_port #(.DATA_W(DATA_W)) u_port_cart (
      .req(region_req[mem_map_pkg::R_CART]), .master_addr(m_addr), .master_wdata(m_wdata),
      .master_we_n(m_we_n), .master_re_n(m_re_n),
      .addr(cart_addr), .wdata(cart_wdata), .we_n(cart_we_n), .re_n(cart_re_n)
   );
   region_port #(.DATA_W(DATA_W)) u_port_lcdram (
      .req(region_req[mem_map_pkg::R_LCDRAM]), .master_addr(m_addr), .master_wdata(m_wdata),
      .master_we_n(m_we_n), .master_re_n(m_re_n),
      .addr(lcdram_addr), .wdata(lcdram_wdata), .we_n(lcdram_we_n), .re_n(lcdram_re_n)
   );
   region_port #(.DATA_W(DATA_W)) u_port_wram (
      .req(region_req[mem_map_pkg::R_WRAM]), .master_addr(m_addr), .master_wdata(m_wdata),
      .master_we_n(m_we_n), .master_re_n(m_re_n),
      .addr(wram_addr), .wdata(wram_wdata), .we_n(wram_we_n), .re_n(wram_re_n)
   );
   region_port #(.DATA_W(DATA_W)) u_port_oam (
      .req(region_req[mem_map_pkg::R_OAM]), .master_addr(m_addr), .master_wdata(m_wdata),
      .master_we_n(m_we_n), .master_re_n(m_re_n),
      .addr(oam_addr), .wdata(oam_wdata), .we_n(oam_we_n), .re_n(oam_re_n)
   );
   region_port #(.DATA_W(DATA_W)) u_port_ioreg (
      .req(region_req[mem_map_pkg::R_IOREG]), .master_addr(m_addr), .master_wdata(m_wdata),
      .master_we_n(m_we_n), .master_re_n(m_re_n),
      .addr(ioreg_addr), .wdata(ioreg_wdata), .we_n(ioreg_we_n), .re_n(ioreg_re_n)
   );
   region_port #(.DATA_W(DATA_W)) u_port_lwram (
      .req(region_req[mem_map_pkg::R_LWRAM]), .master_addr(m_addr), .master_wdata(m_wdata),
      .master_we_n(m_we_n), .master_re_n(m_re_n),
      .addr(lwram_addr), .wdata(lwram_wdata), .we_n(lwram_we_n), .re_n(lwram_re_n)
   );

   // Each reading master sees the region its own address selects.
   read_return #(.DATA_W(DATA_W)) u_ret_cpu (
      .sel(sel_cpu), .re_n(cpu_re_n), .region_rdata(region_rdata), .rdata(cpu_rdata)
   );
   read_return #(.DATA_W(DATA_W)) u_ret_ppu (
      .sel(sel_ppu), .re_n(ppu_re_n), .region_rdata(region_rdata), .rdata(ppu_rdata)
   );
   read_return #(.DATA_W(DATA_W)) u_ret_rdma (
      .sel(sel_rdma), .re_n(rdma_re_n), .region_rdata(region_rdata), .rdata(rdma_rdata)
   );

   access_monitor u_access_monitor (
      .clk(clk), .arst_n(arst_n),
      .sel_cpu(sel_cpu), .sel_ppu(sel_ppu), .sel_rdma(sel_rdma), .sel_wdma(sel_wdma),
      .same_port_error(same_port_error)
   );

endmodule

// File: tb/memory_router_tb.sv
`timescale 1ns/1ps

module memory_router_tb;

   localparam int DATA_W  = 8;
   localparam int MAX_VEC = 64;
   localparam int SWEEP_N = 200;
   localparam int CLK_NS  = 40;

   // The console's address map from cart up to lwram. HI is exclusive.
   localparam logic [5:0][15:0] REGION_LO = {16'hff80, 16'hff00, 16'hfe00,
                                             16'hc000, 16'h8000, 16'h0000};
   localparam logic [5:0][15:0] REGION_HI = {16'hffff, 16'hff80, 16'hfea0,
                                             16'he000, 16'ha000, 16'h8000};

   logic clk;
   logic arst_n;

   // The master side is indexed in the order cpu, ppu, rdma and wdma.
   logic [3:0][15:0]       m_addr;
   logic [3:0][DATA_W-1:0] m_wdata;
   logic [3:0]             m_we_n;
   logic [3:0]             m_re_n;
   logic [2:0][DATA_W-1:0] m_rdata;

   // Slave side by region index.
   logic [5:0][15:0]       s_addr;
   logic [5:0][DATA_W-1:0] s_wdata;
   logic [5:0]             s_we_n;
   logic [5:0]             s_re_n;
   logic [5:0][DATA_W-1:0] s_rdata;
   logic                   same_port_error;

   logic [3:0][15:0]       vec_addr  [MAX_VEC];
   logic [3:0][DATA_W-1:0] vec_wdata [MAX_VEC];
   logic [3:0]             vec_we_n  [MAX_VEC];
   logic [3:0]             vec_re_n  [MAX_VEC];
   logic [5:0][DATA_W-1:0] vec_rdata [MAX_VEC];

   int          n_vec;
   bit          loaded;
   int          errors;
   int          checks;
   logic        exp_error;
   logic [31:0] lfsr_state;

   memory_router #(.DATA_W(DATA_W)) dut (
      .clk(clk), .arst_n(arst_n),
      .cpu_addr(m_addr[0]), .cpu_wdata(m_wdata[0]), .cpu_we_n(m_we_n[0]),
      .cpu_re_n(m_re_n[0]), .cpu_rdata(m_rdata[0]),
      .ppu_addr(m_addr[1]), .ppu_wdata(m_wdata[1]), .ppu_we_n(m_we_n[1]),
      .ppu_re_n(m_re_n[1]), .ppu_rdata(m_rdata[1]),
      .rdma_addr(m_addr[2]), .rdma_re_n(m_re_n[2]), .rdma_rdata(m_rdata[2]),
      .wdma_addr(m_addr[3]), .wdma_wdata(m_wdata[3]), .wdma_we_n(m_we_n[3]),
      .cart_addr(s_addr[0]), .cart_wdata(s_wdata[0]), .cart_we_n(s_we_n[0]),
      .cart_re_n(s_re_n[0]), .cart_rdata(s_rdata[0]),
      .lcdram_addr(s_addr[1]), .lcdram_wdata(s_wdata[1]), .lcdram_we_n(s_we_n[1]),
      .lcdram_re_n(s_re_n[1]), .lcdram_rdata(s_rdata[1]),
      .wram_addr(s_addr[2]), .wram_wdata(s_wdata[2]), .wram_we_n(s_we_n[2]),
      .wram_re_n(s_re_n[2]), .wram_rdata(s_rdata[2]),
      .oam_addr(s_addr[3]), .oam_wdata(s_wdata[3]), .oam_we_n(s_we_n[3]),
      .oam_re_n(s_re_n[3]), .oam_rdata(s_rdata[3]),
      .ioreg_addr(s_addr[4]), .ioreg_wdata(s_wdata[4]), .ioreg_we_n(s_we_n[4]),
      .ioreg_re_n(s_re_n[4]), .ioreg_rdata(s_rdata[4]),
      .lwram_addr(s_addr[5]), .lwram_wdata(s_wdata[5]), .lwram_we_n(s_we_n[5]),
      .lwram_re_n(s_re_n[5]), .lwram_rdata(s_rdata[5]),
      .same_port_error(same_port_error)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_NS / 2) clk = ~clk;
      end
   end

   function automatic string region_name(input int r);
      case (r)
         0:       return "cart";
         1:       return "lcdram";
         2:       return "wram";
         3:       return "oam";
         4:       return "ioreg";
         default: return "lwram";
      endcase
   endfunction

   // Returns the region index of an address, or -1 inside a gap.
   function automatic int region_of(input logic [15:0] a);
      int r;
      r = -1;
      for (int i = 0; i < 6; i++) begin
         if (a >= REGION_LO[i] && a < REGION_HI[i]) begin
            r = i;
         end
      end
      return r;
   endfunction

   // Fibonacci LFSR with taps 32, 22, 2 and 1. It steps once per bit taken.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic load_vectors();
      int              fd;
      int              n;
      logic [1023:0]   line;
      logic [15:0]     ca, pa, ra, wa;
      logic [DATA_W-1:0] cd, pd, wd;
      logic            cw, cr, pw, pr, rr, ww;
      logic [DATA_W-1:0] d0, d1, d2, d3, d4, d5;
      n_vec = 0;
      fd = $fopen("tb/router_stimulus.txt", "r");
      if (fd == 0) begin
         $display("The stimulus file tb/router_stimulus.txt could not be opened.");
         errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = '0;
         if ($fgets(line, fd) == 0) begin
            break;
         end
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     ca, cd, cw, cr, pa, pd, pw, pr, ra, rr, wa, wd, ww,
                     d0, d1, d2, d3, d4, d5);
         if (n == 19 && n_vec < MAX_VEC) begin
            vec_addr[n_vec]  = {wa, ra, pa, ca};
            vec_wdata[n_vec] = {wd, {DATA_W{1'b0}}, pd, cd};
            vec_we_n[n_vec]  = {ww, 1'b1, pw, cw};
            vec_re_n[n_vec]  = {1'b1, rr, pr, cr};
            vec_rdata[n_vec] = {d5, d4, d3, d2, d1, d0};
            n_vec++;
         end else if (n > 0) begin
            $display("A stimulus line has %0d fields instead of 19, or too many lines.", n);
            errors++;
         end
      end
      $fclose(fd);
   endtask

   task automatic drive(input logic [3:0][15:0] a, input logic [3:0][DATA_W-1:0] d,
                        input logic [3:0] we, input logic [3:0] re,
                        input logic [5:0][DATA_W-1:0] rd);
      m_addr  <= a;
      m_wdata <= d;
      m_we_n  <= we;
      m_re_n  <= re;
      s_rdata <= rd;
   endtask

   task automatic random_vector();
      logic [3:0][15:0]       a;
      logic [3:0][DATA_W-1:0] d;
      logic [3:0]             we;
      logic [3:0]             re;
      logic [5:0][DATA_W-1:0] rd;
      for (int m = 0; m < 4; m++) begin
         a[m] = rand_bits(16);
         if (rand_bits(1)) begin
            a[m][15:9] = 7'h7f; // Half the addresses land in the crowded top page.
         end
         d[m]  = rand_bits(DATA_W);
         we[m] = rand_bits(1);
         re[m] = rand_bits(1);
      end
      for (int r = 0; r < 6; r++) begin
         rd[r] = rand_bits(DATA_W);
      end
      drive(a, d, we, re, rd);
   endtask

   // Predicts every output from the inputs now on the bus and compares.
   task automatic check_outputs();
      int                     hit [4];
      int                     win;
      int                     count;
      logic                   clash;
      logic [3:0]             we_eff;
      logic [3:0]             re_eff;
      logic [3:0][DATA_W-1:0] wd_eff;
      logic [DATA_W-1:0]      exp_rdata;
      we_eff    = m_we_n | 4'b0100; // The DMA read port has no write strobe.
      re_eff    = m_re_n | 4'b1000; // The DMA write port has no read strobe.
      wd_eff    = m_wdata;
      wd_eff[2] = '0;
      clash     = 1'b0;
      for (int m = 0; m < 4; m++) begin
         hit[m] = (!we_eff[m] || !re_eff[m]) ? region_of(m_addr[m]) : -1;
      end
      for (int r = 0; r < 6; r++) begin
         win = -1;
         count = 0;
         for (int m = 0; m < 4; m++) begin
            if (hit[m] == r) begin
               if (win < 0) begin
                  win = m;
               end
               count++;
            end
         end
         clash = clash | (count >= 2);
         if (win < 0) begin
            compare({region_name(r), "_addr"}, s_addr[r], 0);
            compare({region_name(r), "_wdata"}, s_wdata[r], 0);
            compare({region_name(r), "_we_n"}, s_we_n[r], 1);
            compare({region_name(r), "_re_n"}, s_re_n[r], 1);
         end else begin
            compare({region_name(r), "_addr"}, s_addr[r], m_addr[win]);
            compare({region_name(r), "_wdata"}, s_wdata[r], wd_eff[win]);
            compare({region_name(r), "_we_n"}, s_we_n[r], we_eff[win]);
            compare({region_name(r), "_re_n"}, s_re_n[r], re_eff[win]);
         end
      end
      for (int m = 0; m < 3; m++) begin
         exp_rdata = '0;
         if (!re_eff[m] && hit[m] >= 0) begin
            exp_rdata = s_rdata[hit[m]];
         end
         compare(m == 0 ? "cpu_rdata" : (m == 1 ? "ppu_rdata" : "rdma_rdata"),
                 m_rdata[m], exp_rdata);
      end
      // The flag registers this vector's clash at the next rising edge.
      compare("same_port_error", same_port_error, exp_error);
      exp_error = exp_error | clash;
   endtask

   initial begin
      wait (loaded);
      #((n_vec + SWEEP_N + 10) * CLK_NS);
      $display("Timeout. The run did not finish in the time allowed for its vectors.");
      $display("Test failed");
      $finish;
   end

   initial begin
      arst_n     = 1'b0;
      m_addr     = '0;
      m_wdata    = '0;
      m_we_n     = '1;
      m_re_n     = '1;
      s_rdata    = '0;
      errors     = 0;
      checks     = 0;
      exp_error  = 1'b0;
      lfsr_state = 32'hf15d_b2a6;
      load_vectors();
      if (n_vec == 0) begin
         $display("No vectors were read from the stimulus file.");
         errors++;
      end
      loaded = 1'b1;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;

      for (int v = 0; v < n_vec; v++) begin
         @(posedge clk);
         drive(vec_addr[v], vec_wdata[v], vec_we_n[v], vec_re_n[v], vec_rdata[v]);
         @(negedge clk);
         check_outputs();
      end

      // Only a reset clears the flag.
      @(posedge clk);
      arst_n <= 1'b0;
      drive('0, '0, '1, '1, '0);
      @(negedge clk);
      compare("same_port_error", same_port_error, 1'b0);
      exp_error = 1'b0;
      @(posedge clk);
      arst_n <= 1'b1;

      repeat (SWEEP_N) begin
         @(posedge clk);
         random_vector();
         @(negedge clk);
         check_outputs();
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: tb/router_stimulus.txt
# cpu: addr wdata we_n re_n | ppu: addr wdata we_n re_n | rdma: addr re_n
# wdma: addr wdata we_n | slave rdata: cart lcdram wram oam ioreg lwram
# CPU alone on each region.
1234 a5 0 1 0000 00 1 1 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
8100 00 1 0 0000 00 1 1 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
c010 3c 0 1 0000 00 1 1 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
fe10 00 1 0 0000 00 1 1 0000 1 0000 00 1 c1 c2 c3 4e c5 c6
ff40 77 0 1 0000 00 1 1 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
ff90 00 1 0 0000 00 1 1 0000 1 0000 00 1 c1 c2 c3 4e c5 6f
# PPU alone, on the first and last words of regions.
0000 00 1 1 0100 00 1 0 0000 1 0000 00 1 1a c2 c3 c4 c5 c6
0000 00 1 1 9fff 5a 0 1 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
0000 00 1 1 dfff 00 1 0 0000 1 0000 00 1 c1 c2 3b c4 c5 c6
0000 00 1 1 fe9f e7 0 1 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
0000 00 1 1 ff7f 00 1 0 0000 1 0000 00 1 c1 c2 c3 c4 5d c6
0000 00 1 1 fffe 00 1 0 0000 1 0000 00 1 c1 c2 c3 c4 c5 8e
# DMA read port alone.
0000 00 1 1 0000 00 1 1 7fff 0 0000 00 1 91 c2 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 8000 0 0000 00 1 c1 92 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 c000 0 0000 00 1 c1 c2 93 c4 c5 c6
0000 00 1 1 0000 00 1 1 fe00 0 0000 00 1 c1 c2 c3 94 c5 c6
0000 00 1 1 0000 00 1 1 ff00 0 0000 00 1 c1 c2 c3 c4 95 c6
0000 00 1 1 0000 00 1 1 ff80 0 0000 00 1 c1 c2 c3 c4 c5 96
# DMA write port alone.
0000 00 1 1 0000 00 1 1 0000 1 0000 11 0 c1 c2 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 0000 1 9000 22 0 c1 c2 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 0000 1 d000 33 0 c1 c2 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 0000 1 fe50 44 0 c1 c2 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 0000 1 ff01 55 0 c1 c2 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 0000 1 ffc0 66 0 c1 c2 c3 c4 c5 c6
# Gap addresses select no region and read back zero.
a000 00 1 0 0000 00 1 1 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
0000 00 1 1 bfff 00 1 0 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 e000 0 0000 00 1 c1 c2 c3 c4 c5 c6
0000 00 1 1 0000 00 1 1 0000 1 fea0 7a 0 c1 c2 c3 c4 c5 c6
ffff 00 1 0 0000 00 1 1 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
0000 00 1 1 feff 00 1 0 0000 1 0000 00 1 c1 c2 c3 c4 c5 c6
# Collisions. The lowest master index takes the region.
c100 00 1 0 c200 00 1 0 0000 1 0000 00 1 c1 c2 a3 c4 c5 c6
0000 00 1 1 fe00 00 1 0 0000 1 fe01 9d 0 c1 c2 c3 b4 c5 c6
0000 00 1 1 0000 00 1 1 1000 0 2000 44 0 d1 c2 c3 c4 c5 c6
ff10 01 0 1 ff20 00 1 0 ff30 0 ff40 04 0 c1 c2 c3 c4 e5 c6
# Single masters again while the error flag holds.
4000 2b 0 1 8800 00 1 0 0000 1 0000 00 1 c1 f2 c3 c4 c5 c6

// File: verilog.f
design/mem_map_pkg.sv
design/addr_decoder.sv
design/region_port.sv
design/read_return.sv
design/access_monitor.sv
design/memory_router.sv
tb/memory_router_tb.sv

// File: Bender.yml
package:
  name: memory_router

sources:
  - design/mem_map_pkg.sv
  - design/addr_decoder.sv
  - design/region_port.sv
  - design/read_return.sv
  - design/access_monitor.sv
  - design/memory_router.sv
  - target: simulation
    files:
      - tb/memory_router_tb.sv
